//--- list.f
+incdir+logic
logic/pipePkg.sv
logic/stageReg.sv
logic/hazardDetect.sv
logic/pipeControl.sv
logic/pipelineCore.sv
verif/pipelineProps.sv
verif/tbPipeline.sv

//--- verif/tbPipeline.sv
/*
 * Pipeline core testbench.
 * LCG-driven fetch stream with freezes, exceptions and branch results.
 * Checking is done by the bound property module.
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module tbPipeline;
    import pipePkg::*;

    localparam int NUM_CYCLES    = 800;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int EMPTY_NEEDED  = 8;

    logic              clk;
    logic              arstN;
    uopT               fetchUop;
    stallCauseT        stallCause;
    branchResT         branchRes;
    logic              exceptionFlush;
    logic              fetchAdvance;
    uopT               retireUop;
    disWrT             disWr;
    cacheCtrlT         cacheCtrl;

    logic [31:0]       lcgState;
    logic [`TAG_W-1:0] nextTag;
    logic              seenValid;
    logic [`TAG_W-1:0] seenTag;
    int                retireCount;
    int                timeoutCount;
    int                otherErrors;
    int                assertFails;

    pipelineCore UUT (
        .clk(clk),
        .arstN(arstN),
        .fetchUop(fetchUop),
        .stallCause(stallCause),
        .branchRes(branchRes),
        .exceptionFlush(exceptionFlush),
        .fetchAdvance(fetchAdvance),
        .retireUop(retireUop),
        .disWr(disWr),
        .cacheCtrl(cacheCtrl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function int unsigned nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {16'h0000, lcgState[31:16]};
    endfunction

    task driveIdle();
        fetchUop       = '0;
        fetchUop.tag   = nextTag;
        stallCause     = '0;
        branchRes      = '0;
        exceptionFlush = ~`FLUSH_ENABLE;
    endtask

    task driveRandom(input logic advanced);
        int unsigned r;
        r = nextRandom();
        stallCause = '0;
        if (r % 16 == 0) begin
            stallCause = stallCauseT'(5'b00001 << ((r >> 4) % 5));
        end
        r = nextRandom();
        exceptionFlush = (r % 40 == 0) ? `FLUSH_ENABLE : ~`FLUSH_ENABLE;
        r = nextRandom();
        branchRes = '0;
        if (r % 10 == 0) begin
            branchRes.predictFailed = 1'b1;
        end else if (r % 30 == 1) begin
            branchRes.flushAll = 1'b1;
        end
        if (branchRes.predictFailed || branchRes.flushAll) begin
            branchRes.isLikely = r[8];
            branchRes.taken    = r[9];
        end
        // new token only once the fetch source has stepped
        if (advanced) begin
            nextTag = nextTag + 1'b1;
            r = nextRandom();
            // registers 0..3 so load-use pairs are frequent
            fetchUop.valid     = (r[11:9] != 3'b000);
            fetchUop.tag       = nextTag;
            fetchUop.src0      = `REG_W'(r[1:0]);
            fetchUop.src1      = `REG_W'(r[3:2]);
            fetchUop.dest      = `REG_W'(r[5:4]);
            fetchUop.isLoad    = r[6];
            fetchUop.writesReg = r[6] | r[7];
        end
    endtask

    // distinct valid tokens seen at WB
    always @(negedge clk) begin
        if (arstN && retireUop.valid && (!seenValid || retireUop.tag != seenTag)) begin
            retireCount++;
        end
        seenValid = retireUop.valid;
        seenTag   = retireUop.tag;
    end

    initial begin
        int   emptyCycles;
        int   waited;
        logic adv;
        lcgState     = 32'd78;
        nextTag      = '0;
        seenValid    = 1'b0;
        seenTag      = '0;
        retireCount  = 0;
        timeoutCount = 0;
        otherErrors  = 0;
        arstN        = 1'b1;
        driveIdle();
        #1 arstN = 1'b0;
        repeat (16) @(posedge clk);
        #1 arstN = 1'b1;

        // a few cause-free cycles right after release
        repeat (3) @(posedge clk);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk);
            adv = fetchAdvance;
            @(posedge clk);
            #1;
            driveRandom(adv);
        end

        @(posedge clk);
        #1 driveIdle();
        emptyCycles = 0;
        waited      = 0;
        while (emptyCycles < EMPTY_NEEDED && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            if (retireUop.valid) begin
                emptyCycles = 0;
            end else begin
                emptyCycles++;
            end
            waited++;
        end
        if (emptyCycles < EMPTY_NEEDED) begin
            $display("pipeline did not drain within %0d cycles", DRAIN_TIMEOUT);
            timeoutCount++;
        end
        if (retireCount == 0) begin
            $display("no micro-op retired during the run");
            otherErrors++;
        end

        @(posedge clk);
        #1;
        assertFails = UUT.ruleCheck.failCount;
        $display("assertion failures %0d, timeouts %0d, other errors %0d, retired %0d",
                 assertFails, timeoutCount, otherErrors, retireCount);
        if (assertFails == 0 && timeoutCount == 0 && otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verif/pipelineProps.sv
/*
 * Pipeline core properties.
 * Concurrent checks on reset, freeze, exception, mispredict, retire order,
 * load-use stalls and load-use bubbles, bound to the pipeline top.
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipelineProps (
    input  logic                clk,
    input  logic                arstN,
    input  pipePkg::stallCauseT stallCause,
    input  pipePkg::branchResT  branchRes,
    input  logic                exceptionFlush,
    input  pipePkg::hazardT     hazard,
    input  logic                fetchAdvance,
    input  pipePkg::uopT        retireUop,
    input  pipePkg::disWrT      disWr,
    input  pipePkg::cacheCtrlT  cacheCtrl
);
    import pipePkg::*;

    int                failCount = 0;
    logic              freeze;
    logic              exceptionHit;
    logic              prevFreeze;
    logic              newRetire;
    logic              haveLast;
    logic [`TAG_W-1:0] lastTag;
    logic [`TAG_W-1:0] tagStep;
    uopT               lastWb;
    logic              lastIsLoad;
    logic              readsLast;

    assign freeze       = |stallCause;
    assign exceptionHit = (exceptionFlush == `FLUSH_ENABLE);

    // WB only holds under a freeze, so a fresh occupant follows any unfrozen edge
    assign newRetire  = !prevFreeze;
    assign tagStep    = retireUop.tag - lastTag;
    assign lastIsLoad = lastWb.valid && lastWb.isLoad && lastWb.writesReg &&
                        (lastWb.dest != {`REG_W{1'b0}});
    assign readsLast  = retireUop.valid &&
                        ((retireUop.src0 == lastWb.dest) || (retireUop.src1 == lastWb.dest));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prevFreeze <= 1'b0;
            haveLast   <= 1'b0;
            lastTag    <= '0;
            lastWb     <= '0;
        end else begin
            prevFreeze <= freeze;
            if (newRetire) begin
                lastWb <= retireUop;
                if (retireUop.valid) begin
                    haveLast <= 1'b1;
                    lastTag  <= retireUop.tag;
                end
            end
        end
    end

    resetEmpty: assert property (@(posedge clk) (!arstN || $rose(arstN)) |-> !retireUop.valid)
        else begin
            failCount++;
            $error("ERROR %0t retireUop.valid expected 0 got %b", $time,
                   $sampled(retireUop.valid));
        end

    // no cause at all means every stage advances and both caches may request
    quietAdvance: assert property (@(posedge clk) disable iff (!arstN)
        (!freeze && !exceptionHit && !branchRes.predictFailed && !branchRes.flushAll &&
         hazard == '0) |-> (fetchAdvance && cacheCtrl.iReqValid && cacheCtrl.dReqValid))
        else begin
            failCount++;
            $error("ERROR %0t fetchAdvance,iReqValid,dReqValid expected 111 got %b%b%b", $time,
                   $sampled(fetchAdvance), $sampled(cacheCtrl.iReqValid),
                   $sampled(cacheCtrl.dReqValid));
        end

    freezeControls: assert property (@(posedge clk) disable iff (!arstN)
        freeze |-> (!fetchAdvance && cacheCtrl.iCacheStall && cacheCtrl.dCacheStall &&
                    disWr.exe && disWr.mem && disWr.wb))
        else begin
            failCount++;
            $error("ERROR %0t freeze controls expected 011111 got %b%b%b%b%b%b", $time,
                   $sampled(fetchAdvance), $sampled(cacheCtrl.iCacheStall),
                   $sampled(cacheCtrl.dCacheStall), $sampled(disWr.exe),
                   $sampled(disWr.mem), $sampled(disWr.wb));
        end

    freezeHolds: assert property (@(posedge clk) disable iff (!arstN)
        freeze |=> $stable(retireUop))
        else begin
            failCount++;
            $error("ERROR %0t retireUop expected %h got %h", $time,
                   $past(retireUop), $sampled(retireUop));
        end

    exceptionRequests: assert property (@(posedge clk) disable iff (!arstN)
        (exceptionHit && !freeze) |->
            (!cacheCtrl.iReqValid && !cacheCtrl.dReqValid && fetchAdvance))
        else begin
            failCount++;
            $error("ERROR %0t iReqValid,dReqValid,fetchAdvance expected 001 got %b%b%b", $time,
                   $sampled(cacheCtrl.iReqValid), $sampled(cacheCtrl.dReqValid),
                   $sampled(fetchAdvance));
        end

    // flushAll outranks load-use, predictFailed does not
    mispredictRedirect: assert property (@(posedge clk) disable iff (!arstN)
        (!freeze && !exceptionHit &&
         (branchRes.flushAll || (branchRes.predictFailed && hazard == '0))) |->
            (fetchAdvance && !cacheCtrl.iReqValid && !cacheCtrl.iCacheStall))
        else begin
            failCount++;
            $error("ERROR %0t fetchAdvance,iReqValid,iCacheStall expected 100 got %b%b%b", $time,
                   $sampled(fetchAdvance), $sampled(cacheCtrl.iReqValid),
                   $sampled(cacheCtrl.iCacheStall));
        end

    // load only in EXE holds the front end and keeps the ID consumer from writing
    exLoadUseStall: assert property (@(posedge clk) disable iff (!arstN)
        (!freeze && !exceptionHit && !branchRes.flushAll && hazard.idExStall &&
         !hazard.idMem1Stall && !hazard.idMem2Stall) |->
            (!fetchAdvance && cacheCtrl.iCacheStall && disWr.id))
        else begin
            failCount++;
            $error("ERROR %0t fetchAdvance,iCacheStall,disWr.id expected 011 got %b%b%b", $time,
                   $sampled(fetchAdvance), $sampled(cacheCtrl.iCacheStall),
                   $sampled(disWr.id));
        end

    // modulo compare, tags wrap during long runs
    retireOrder: assert property (@(posedge clk) disable iff (!arstN)
        (newRetire && retireUop.valid && haveLast) |->
            (tagStep != '0 && !tagStep[`TAG_W-1]))
        else begin
            failCount++;
            $error("ERROR %0t retireUop.tag expected after %h got %h", $time,
                   $sampled(lastTag), $sampled(retireUop.tag));
        end

    loadUseBubble: assert property (@(posedge clk) disable iff (!arstN)
        (newRetire && lastIsLoad) |-> !readsLast)
        else begin
            failCount++;
            $error("ERROR %0t retireUop sources expected not %h got %h,%h", $time,
                   $sampled(lastWb.dest), $sampled(retireUop.src0), $sampled(retireUop.src1));
        end

endmodule

bind pipelineCore pipelineProps ruleCheck (
    .clk(clk),
    .arstN(arstN),
    .stallCause(stallCause),
    .branchRes(branchRes),
    .exceptionFlush(exceptionFlush),
    .hazard(hazard),
    .fetchAdvance(fetchAdvance),
    .retireUop(retireUop),
    .disWr(disWr),
    .cacheCtrl(cacheCtrl)
);

//--- logic/pipelineCore.sv
/*
 * Pipeline core top.
 * Six stage registers from IF to WB, steered by the stage control network
 * and fed by the load-use hazard detector.
 */
`timescale 1ns/1ps

module pipelineCore (
    input  logic                clk,
    input  logic                arstN,
    input  pipePkg::uopT        fetchUop,
    input  pipePkg::stallCauseT stallCause,
    input  pipePkg::branchResT  branchRes,
    input  logic                exceptionFlush,
    output logic                fetchAdvance,
    output pipePkg::uopT        retireUop,
    output pipePkg::disWrT      disWr,
    output pipePkg::cacheCtrlT  cacheCtrl
);
    import pipePkg::*;

    uopT       ifUop;
    uopT       idUop;
    uopT       exeUop;
    uopT       memUop;
    uopT       mem2Uop;
    uopT       wbUop;
    hazardT    hazard;
    stageCtrlT stageCtrl;

    // bit i of wr and flush belongs to the same stage, IF at 5 down to WB at 0
    stageReg ifReg (
        .clk(clk), .arstN(arstN), .wr(stageCtrl.wr[5]), .flush(stageCtrl.flush[5]),
        .dIn(fetchUop), .q(ifUop)
    );
    stageReg idReg (
        .clk(clk), .arstN(arstN), .wr(stageCtrl.wr[4]), .flush(stageCtrl.flush[4]),
        .dIn(ifUop), .q(idUop)
    );
    stageReg exeReg (
        .clk(clk), .arstN(arstN), .wr(stageCtrl.wr[3]), .flush(stageCtrl.flush[3]),
        .dIn(idUop), .q(exeUop)
    );
    stageReg memReg (
        .clk(clk), .arstN(arstN), .wr(stageCtrl.wr[2]), .flush(stageCtrl.flush[2]),
        .dIn(exeUop), .q(memUop)
    );
    stageReg mem2Reg (
        .clk(clk), .arstN(arstN), .wr(stageCtrl.wr[1]), .flush(stageCtrl.flush[1]),
        .dIn(memUop), .q(mem2Uop)
    );
    stageReg wbReg (
        .clk(clk), .arstN(arstN), .wr(stageCtrl.wr[0]), .flush(stageCtrl.flush[0]),
        .dIn(mem2Uop), .q(wbUop)
    );

    hazardDetect hazardDetect (
        .idUop(idUop),
        .exeUop(exeUop),
        .memUop(memUop),
        .mem2Uop(mem2Uop),
        .hazard(hazard)
    );

    pipeControl pipeControl (
        .stallCause(stallCause),
        .branchRes(branchRes),
        .exceptionFlush(exceptionFlush),
        .hazard(hazard),
        .stageCtrl(stageCtrl),
        .disWr(disWr),
        .cacheCtrl(cacheCtrl)
    );

    // PREIF write tells the fetch source to step
    assign fetchAdvance = stageCtrl.wr[6];
    assign retireUop    = wbUop;

endmodule

//--- logic/pipeControl.sv
/*
 * Pipeline stage control.
 * Combinational priority network that turns freeze, exception, branch and
 * load-use causes into per-stage writes, flushes, write disables and cache levels.
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipeControl (
    input  pipePkg::stallCauseT stallCause,
    input  pipePkg::branchResT  branchRes,
    input  logic                exceptionFlush,
    input  pipePkg::hazardT     hazard,
    output pipePkg::stageCtrlT  stageCtrl,
    output pipePkg::disWrT      disWr,
    output pipePkg::cacheCtrlT  cacheCtrl
);

    logic freeze;
    logic exceptionHit;
    logic likelyNotTaken;
    logic iStall;
    logic dStall;
    logic iReqValid;
    logic dReqValid;

    // data side, instruction side and mul/div all freeze the same way
    assign freeze = stallCause.dTlbStall  | stallCause.dCacheBusy |
                    stallCause.iTlbStall  | stallCause.iCacheBusy |
                    stallCause.mulDivBusy;

    assign exceptionHit = (exceptionFlush == `FLUSH_ENABLE);

    // delay slot of a not-taken likely branch is nullified
    assign likelyNotTaken = branchRes.isLikely & ~branchRes.taken;

    always_comb begin
        // every stage advancing by default
        stageCtrl.wr    = 7'b111_1111;
        stageCtrl.flush = 6'b00_0000;
        disWr           = '0;
        iStall          = 1'b0;
        dStall          = 1'b0;

        if (freeze) begin
            // whole pipe holds, caches keep their data ready
            stageCtrl.wr    = 7'b000_0000;
            stageCtrl.flush = 6'b00_0000;
            disWr.exe       = 1'b1;
            disWr.mem       = 1'b1;
            disWr.wb        = 1'b1;
            iStall          = 1'b1;
            dStall          = 1'b1;
        end else if (exceptionHit) begin
            // drain MEM2 and WB, kill everything younger
            stageCtrl.wr    = 7'b100_0011;
            stageCtrl.flush = 6'b11_1100;
            disWr.exe       = 1'b1;
            disWr.mem       = 1'b1;
        end else if (branchRes.flushAll) begin
            stageCtrl.wr    = 7'b100_1111;
            stageCtrl.flush = 6'b11_1000;
        end else if (hazard.idMem2Stall) begin
            // load in MEM2 moves on, bubble into MEM2
            stageCtrl.wr    = 7'b000_0011;
            stageCtrl.flush = 6'b00_0010;
            disWr.mem       = 1'b1;
            iStall          = 1'b1;
        end else if (hazard.idMem1Stall) begin
            stageCtrl.wr    = 7'b000_0111;
            stageCtrl.flush = 6'b00_0100;
            disWr.exe       = 1'b1;
            iStall          = 1'b1;
        end else if (hazard.idExStall) begin
            // bubble into EXE, consumer waits in ID
            stageCtrl.wr    = 7'b000_1111;
            stageCtrl.flush = 6'b00_1000;
            disWr.id        = 1'b1;
            iStall          = 1'b1;
        end else if (branchRes.predictFailed) begin
            stageCtrl.wr    = 7'b100_1111;
            stageCtrl.flush = {2'b11, likelyNotTaken, 3'b000};
        end
    end

    // no new fetch while the front end is being redirected or held
    always_comb begin
        iReqValid = 1'b1;
        if (exceptionHit || hazard.idExStall || hazard.idMem1Stall ||
            hazard.idMem2Stall || branchRes.predictFailed || branchRes.flushAll) begin
            iReqValid = 1'b0;
        end
    end

    always_comb begin
        dReqValid = 1'b1;
        if (exceptionHit) begin
            dReqValid = 1'b0;
        end
    end

    assign cacheCtrl = '{
        iReqValid:   iReqValid,
        dReqValid:   dReqValid,
        iCacheStall: iStall,
        dCacheStall: dStall
    };

endmodule

//--- logic/hazardDetect.sv
/*
 * Load-use hazard detector.
 * Compares the ID sources against load destinations held in EXE, MEM and MEM2.
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module hazardDetect (
    input  pipePkg::uopT    idUop,
    input  pipePkg::uopT    exeUop,
    input  pipePkg::uopT    memUop,
    input  pipePkg::uopT    mem2Uop,
    output pipePkg::hazardT hazard
);
    import pipePkg::*;

    logic exeHit;
    logic memHit;
    logic mem2Hit;

    // a load in a later stage whose result ID still needs
    function automatic logic loadFeedsId(input uopT prod, input uopT cons);
        logic producesReg;
        logic srcMatch;
        producesReg = prod.valid && prod.isLoad && prod.writesReg &&
                      (prod.dest != {`REG_W{1'b0}});
        srcMatch    = (prod.dest == cons.src0) || (prod.dest == cons.src1);
        return producesReg && cons.valid && srcMatch;
    endfunction

    // stages checked independently, control picks the winner
    assign exeHit  = loadFeedsId(exeUop, idUop);
    assign memHit  = loadFeedsId(memUop, idUop);
    assign mem2Hit = loadFeedsId(mem2Uop, idUop);

    assign hazard = '{
        idExStall:   exeHit,
        idMem1Stall: memHit,
        idMem2Stall: mem2Hit
    };

endmodule

//--- logic/stageReg.sv
/*
 * Pipeline stage register.
 * Holds one micro-op token, flush clears it and write loads a new one.
 */
`timescale 1ns/1ps

module stageReg (
    input  logic         clk,
    input  logic         arstN,
    input  logic         wr,
    input  logic         flush,
    input  pipePkg::uopT dIn,
    output pipePkg::uopT q
);
    import pipePkg::*;

    logic validQ;
    uopT  tokenQ;

    // flush wins over write, no write holds
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else if (flush) begin
            validQ <= 1'b0;
        end else if (wr) begin
            validQ <= dIn.valid;
        end
    end

    // payload only matters while valid is set
    always_ff @(posedge clk) begin
        if (wr) begin
            tokenQ <= dIn;
        end
    end

    always_comb begin
        q       = tokenQ;
        q.valid = validQ;
    end

endmodule

//--- logic/pipePkg.sv
/*
 * Pipeline types.
 * Micro-op token, stall and branch causes, and the stage control bundles.
 */
`include "pipe_config.svh"

package pipePkg;

    // one instruction moving down the pipe
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
        logic [`REG_W-1:0] src0;
        logic [`REG_W-1:0] src1;
        logic [`REG_W-1:0] dest;
        logic              writesReg;
        logic              isLoad;
    } uopT;

    // freeze causes from TLBs, caches and mul/div unit
    typedef struct packed {
        logic iTlbStall;
        logic dTlbStall;
        logic iCacheBusy;
        logic dCacheBusy;
        logic mulDivBusy;
    } stallCauseT;

    // branch outcome resolved in EXE
    typedef struct packed {
        logic predictFailed;
        logic flushAll;
        logic isLikely;
        logic taken;
    } branchResT;

    typedef struct packed {
        logic idExStall;
        logic idMem1Stall;
        logic idMem2Stall;
    } hazardT;

    // wr is {PREIF, IF, ID, EXE, MEM, MEM2, WB}, flush is {IF, ID, EXE, MEM, MEM2, WB}
    typedef struct packed {
        logic [6:0] wr;
        logic [5:0] flush;
    } stageCtrlT;

    typedef struct packed {
        logic id;
        logic exe;
        logic mem;
        logic wb;
    } disWrT;

    typedef struct packed {
        logic iReqValid;
        logic dReqValid;
        logic iCacheStall;
        logic dCacheStall;
    } cacheCtrlT;

endpackage

//--- logic/pipe_config.svh
/*
 * Pipeline core configuration.
 * Register-number width, micro-op tag width and exception flush polarity.
 */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// architectural register number width
`define REG_W 5

// micro-op sequence tag width
`define TAG_W 8

// active level of the exception flush
`define FLUSH_ENABLE 1'b1

`endif
